// File: verilog/scene_settings.svh
`ifndef SCENE_SETTINGS_SVH
`define SCENE_SETTINGS_SVH

// Horizontal timing in hcount steps
`define H_ACTIVE 1280
`define H_FRONT  32
`define H_SYNC   192
`define H_BACK   96

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33

// Background bands
`define GROUND_LINE_ROW 280
`define DARK_GROUND_ROW 300

// Colours as 24-bit r, g, b
`define SKY_RESET_COLOR    24'h87CEEB
`define GROUND_LIGHT_COLOR 24'h8B4513
`define GROUND_DARK_COLOR  24'h64280A
`define LINE_COLOR         24'h000000
`define GLYPH_COLOR        24'h000000

// Score overlay
`define GLYPH_SIZE    8
`define DIGIT_PITCH   10
`define SCORE_X_RESET 11'd25
`define SCORE_Y_RESET 10'd41

// Register map in word indices
`define REG_SKY     2'd0
`define REG_SCORE_X 2'd1
`define REG_SCORE_Y 2'd2
`define REG_SCORE   2'd3

`endif

// File: verilog/video_pkg.sv
package video_pkg;

    // Beam position
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // One colour channel as sent to the DAC
    typedef logic [7:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // Score digits
    typedef logic [3:0] bcd_digit_t;

    // Index 2 holds the hundreds, index 0 the units
    typedef bcd_digit_t [2:0] score_t;

    // Font row with the MSB as the leftmost pixel
    typedef logic [7:0] glyph_row_t;

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

    // Wishbone data word
    typedef logic [31:0] wb_data_t;

    // Word index into the register bank
    typedef logic [1:0] wb_addr_t;

endpackage

// File: verilog/scene_cfg_if.sv
`timescale 1ns/100ps

interface scene_cfg_if;
    import video_pkg::*;

    rgb_t    sky;
    hcount_t score_x;
    vcount_t score_y;
    score_t  score;

    modport regs (
        output sky, score_x, score_y, score
    );

    modport renderer (
        input sky, score_x, score_y, score
    );

endinterface

// File: verilog/vga_counters.sv
`timescale 1ns/100ps
`include "scene_settings.svh"

module vga_counters (
    input  logic               clk,
    input  logic               reset,
    output video_pkg::hcount_t hcount,
    output video_pkg::vcount_t vcount,
    output logic               active,
    output logic               vga_clk,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_blank_n,
    output logic               vga_sync_n
);
    import video_pkg::*;

    localparam hcount_t H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam vcount_t V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (hcount == H_TOTAL - 1'b1);
    assign end_of_field = (vcount == V_TOTAL - 1'b1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_field ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Sync pulses are active low
    assign vga_hs = !((hcount >= `H_ACTIVE + `H_FRONT) &&
                      (hcount < `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vga_vs = !((vcount >= `V_ACTIVE + `V_FRONT) &&
                      (vcount < `V_ACTIVE + `V_FRONT + `V_SYNC));

    assign active      = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);
    assign vga_blank_n = active;
    assign vga_sync_n  = 1'b0;

    // Pixel clock at half the hcount rate
    assign vga_clk = hcount[0];

endmodule

// File: verilog/scene_regs.sv
`timescale 1ns/100ps
`include "scene_settings.svh"

module scene_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  bus_pkg::wb_addr_t wb_adr,
    input  bus_pkg::wb_data_t wb_dat_w,
    output bus_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    scene_cfg_if.regs         cfg
);
    import video_pkg::*;
    import bus_pkg::*;

    rgb_t     sky;
    hcount_t  score_x;
    vcount_t  score_y;
    score_t   score;
    logic     access;
    wb_data_t read_word;

    // Strobe is ignored while ack is out, so each access acks once
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            sky     <= `SKY_RESET_COLOR;
            score_x <= `SCORE_X_RESET;
            score_y <= `SCORE_Y_RESET;
            score   <= '0;
        end else begin
            wb_ack <= access;
            if (access && wb_we) begin
                case (wb_adr)
                    `REG_SKY:     sky     <= wb_dat_w[$bits(rgb_t)-1:0];
                    `REG_SCORE_X: score_x <= wb_dat_w[$bits(hcount_t)-1:0];
                    `REG_SCORE_Y: score_y <= wb_dat_w[$bits(vcount_t)-1:0];
                    `REG_SCORE:   score   <= wb_dat_w[$bits(score_t)-1:0];
                endcase
            end
        end
    end

    // Right-aligned readback
    always_comb begin
        read_word = '0;
        case (wb_adr)
            `REG_SKY:     read_word[$bits(rgb_t)-1:0]    = sky;
            `REG_SCORE_X: read_word[$bits(hcount_t)-1:0] = score_x;
            `REG_SCORE_Y: read_word[$bits(vcount_t)-1:0] = score_y;
            `REG_SCORE:   read_word[$bits(score_t)-1:0]  = score;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= read_word;
        end
    end

    assign cfg.sky     = sky;
    assign cfg.score_x = score_x;
    assign cfg.score_y = score_y;
    assign cfg.score   = score;

endmodule

// File: verilog/glyph_rom.sv
`timescale 1ns/100ps
`include "scene_settings.svh"

module glyph_rom (
    input  logic                  clk,
    input  video_pkg::bcd_digit_t digit,
    input  logic [2:0]            row,
    output video_pkg::glyph_row_t bits
);
    import video_pkg::*;

    // Digits 0 to 9 with the top row first
    localparam glyph_row_t FONT [0:9][0:`GLYPH_SIZE-1] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
    };

    always_ff @(posedge clk) begin
        if (digit <= 4'd9) begin
            bits <= FONT[digit][row];
        end else begin
            // Not a BCD code
            bits <= '0;
        end
    end

endmodule

// File: verilog/scene_renderer.sv
`timescale 1ns/100ps
`include "scene_settings.svh"

module scene_renderer (
    input  logic                clk,
    input  logic                reset,
    input  video_pkg::hcount_t  hcount,
    input  video_pkg::vcount_t  vcount,
    input  logic                active,
    scene_cfg_if.renderer       cfg,
    output video_pkg::channel_t vga_r,
    output video_pkg::channel_t vga_g,
    output video_pkg::channel_t vga_b
);
    import video_pkg::*;

    localparam int DIGITS = 3;

    rgb_t        band;
    logic        hit;
    logic [2:0]  col;
    logic [10:0] row_off;
    logic        in_rows;
    bcd_digit_t  rom_digit;
    logic [2:0]  rom_row;

    rgb_t        band_q;
    logic [2:0]  col_q;
    logic        hit_q;
    logic        active_q;

    glyph_row_t  rom_bits;
    logic        glyph_on;
    rgb_t        pixel;

    // Stage 1 works out the background band for the row
    always_comb begin
        if (vcount < `GROUND_LINE_ROW) begin
            band = cfg.sky;
        end else if (vcount == `GROUND_LINE_ROW) begin
            band = `LINE_COLOR;
        end else if (vcount < `DARK_GROUND_ROW) begin
            band = `GROUND_LIGHT_COLOR;
        end else begin
            band = `GROUND_DARK_COLOR;
        end
    end

    assign row_off = {1'b0, vcount} - {1'b0, cfg.score_y};
    assign in_rows = (vcount >= cfg.score_y) && (row_off < `GLYPH_SIZE);
    assign rom_row = row_off[2:0];

    // Slot 0 is leftmost and shows the hundreds
    always_comb begin
        logic [11:0] slot_x;
        logic [11:0] col_off;
        hit       = 1'b0;
        col       = '0;
        rom_digit = '1;
        for (int k = 0; k < DIGITS; k++) begin
            slot_x  = {1'b0, cfg.score_x} + 12'(k * `DIGIT_PITCH);
            col_off = {1'b0, hcount} - slot_x;
            if (in_rows && ({1'b0, hcount} >= slot_x) && (col_off < `GLYPH_SIZE)) begin
                hit       = 1'b1;
                col       = col_off[2:0];
                rom_digit = cfg.score[DIGITS-1-k];
            end
        end
    end

    glyph_rom font (
        .clk   (clk),
        .digit (rom_digit),
        .row   (rom_row),
        .bits  (rom_bits)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_q    <= 1'b0;
            active_q <= 1'b0;
        end else begin
            hit_q    <= hit;
            active_q <= active;
        end
    end

    always_ff @(posedge clk) begin
        band_q <= band;
        col_q  <= col;
    end

    // Stage 2 puts the glyph over the band and blacks out blanking
    assign glyph_on = hit_q && rom_bits[`GLYPH_SIZE-1-col_q];

    always_comb begin
        if (!active_q) begin
            pixel = '0;
        end else if (glyph_on) begin
            pixel = `GLYPH_COLOR;
        end else begin
            pixel = band_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else begin
            vga_r <= pixel.r;
            vga_g <= pixel.g;
            vga_b <= pixel.b;
        end
    end

endmodule

// File: verilog/vga_scene.sv
`timescale 1ns/100ps

module vga_scene (
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  bus_pkg::wb_addr_t   wb_adr,
    input  bus_pkg::wb_data_t   wb_dat_w,
    output bus_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack,
    output video_pkg::channel_t vga_r,
    output video_pkg::channel_t vga_g,
    output video_pkg::channel_t vga_b,
    output logic                vga_clk,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                vga_sync_n
);
    import video_pkg::*;

    hcount_t hcount;
    vcount_t vcount;
    logic    active;

    scene_cfg_if cfg ();

    vga_counters counters (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .active      (active),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    scene_regs regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg.regs)
    );

    scene_renderer renderer (
        .clk    (clk),
        .reset  (reset),
        .hcount (hcount),
        .vcount (vcount),
        .active (active),
        .cfg    (cfg.renderer),
        .vga_r  (vga_r),
        .vga_g  (vga_g),
        .vga_b  (vga_b)
    );

endmodule

// File: verification/scene_model_pkg.sv
`include "scene_settings.svh"

package scene_model_pkg;
    import video_pkg::*;
    import bus_pkg::*;

    // Reference digit font with the top row first
    localparam glyph_row_t GLYPHS [0:9][0:7] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
    };

    // Model copy of the register bank
    rgb_t    reg_sky;
    hcount_t reg_score_x;
    vcount_t reg_score_y;
    score_t  reg_score;

    function automatic void reset_regs();
        reg_sky     = `SKY_RESET_COLOR;
        reg_score_x = `SCORE_X_RESET;
        reg_score_y = `SCORE_Y_RESET;
        reg_score   = '0;
    endfunction

    function automatic void write_reg(wb_addr_t adr, wb_data_t data);
        case (adr)
            `REG_SKY:     reg_sky     = data[23:0];
            `REG_SCORE_X: reg_score_x = data[10:0];
            `REG_SCORE_Y: reg_score_y = data[9:0];
            default:      reg_score   = data[11:0];
        endcase
    endfunction

    function automatic wb_data_t read_reg(wb_addr_t adr);
        wb_data_t word;
        word = '0;
        case (adr)
            `REG_SKY:     word[23:0] = reg_sky;
            `REG_SCORE_X: word[10:0] = reg_score_x;
            `REG_SCORE_Y: word[9:0]  = reg_score_y;
            default:      word[11:0] = reg_score;
        endcase
        return word;
    endfunction

    function automatic rgb_t pixel_color(int h, int v);
        int         slot_x;
        bcd_digit_t digit;
        rgb_t       band;
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            return '0;
        end
        if (v < `GROUND_LINE_ROW) begin
            band = reg_sky;
        end else if (v == `GROUND_LINE_ROW) begin
            band = `LINE_COLOR;
        end else if (v < `DARK_GROUND_ROW) begin
            band = `GROUND_LIGHT_COLOR;
        end else begin
            band = `GROUND_DARK_COLOR;
        end
        // Leftmost slot holds the hundreds
        for (int k = 0; k < 3; k++) begin
            slot_x = reg_score_x + k * `DIGIT_PITCH;
            if (h >= slot_x && h < slot_x + `GLYPH_SIZE &&
                v >= reg_score_y && v < reg_score_y + `GLYPH_SIZE) begin
                digit = reg_score[2-k];
                if (digit <= 9 && GLYPHS[digit][v - reg_score_y][7 - (h - slot_x)]) begin
                    return `GLYPH_COLOR;
                end
            end
        end
        return band;
    endfunction

    function automatic logic hsync_level(int h);
        return !(h >= `H_ACTIVE + `H_FRONT && h < `H_ACTIVE + `H_FRONT + `H_SYNC);
    endfunction

    function automatic logic vsync_level(int v);
        return !(v >= `V_ACTIVE + `V_FRONT && v < `V_ACTIVE + `V_FRONT + `V_SYNC);
    endfunction

    function automatic logic blank_level(int h, int v);
        return (h < `H_ACTIVE) && (v < `V_ACTIVE);
    endfunction

endpackage

// File: verification/tb_vga_scene.sv
`timescale 1ns/100ps
`include "scene_settings.svh"

module tb_vga_scene;
    import video_pkg::*;
    import bus_pkg::*;
    import scene_model_pkg::*;

    localparam int H_TOTAL      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CYCLE_LIMIT  = 4 * FRAME_CYCLES + 2000;

    logic     clk = 1'b0;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    channel_t vga_r;
    channel_t vga_g;
    channel_t vga_b;
    logic     vga_clk;
    logic     vga_hs;
    logic     vga_vs;
    logic     vga_blank_n;
    logic     vga_sync_n;

    // Beam position at the current falling edge and two edges of history
    int th;
    int tv;
    int ph [0:1];
    int pv [0:1];

    int cycles = 0;
    int errors = 0;
    int tests_failed = 0;
    int current_test;
    int test_errors [1:5];

    wb_addr_t adr;
    wb_data_t data;
    wb_data_t rdata;
    score_t   new_score;

    vga_scene DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic step();
        @(negedge clk);
        ph[1] = ph[0];
        pv[1] = pv[0];
        ph[0] = th;
        pv[0] = tv;
        if (th == H_TOTAL - 1) begin
            th = 0;
            tv = (tv == V_TOTAL - 1) ? 0 : tv + 1;
        end else begin
            th = th + 1;
        end
    endtask

    task automatic count_error();
        errors++;
        test_errors[current_test]++;
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            count_error();
        end
    endtask

    task automatic check_word(input string name, input wb_data_t expected,
                              input wb_data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            count_error();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
            count_error();
        end
    endtask

    // One Wishbone classic access driven from a falling edge
    task automatic bus_access(input logic we, input wb_addr_t a, input wb_data_t d,
                              output wb_data_t rd);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = a;
        wb_dat_w = d;
        step();
        waited = 1;
        while (!wb_ack && waited < 2) begin
            step();
            waited++;
        end
        if (!wb_ack) begin
            $display("%0t: no acknowledge within 2 cycles for register %0d", $time, a);
            count_error();
        end else if (waited != 1) begin
            $display("%0t: acknowledge for register %0d came late", $time, a);
            count_error();
        end
        rd = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step();
        if (wb_ack) begin
            $display("%0t: acknowledge held for more than one cycle", $time);
            count_error();
        end
    endtask

    task automatic check_frame(input int pixel_test, input bit with_sync);
        rgb_t actual;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (with_sync) begin
                current_test = 3;
                check_bit("vga_hs", hsync_level(th), vga_hs);
                check_bit("vga_vs", vsync_level(tv), vga_vs);
                check_bit("vga_blank_n", blank_level(th, tv), vga_blank_n);
                check_bit("vga_clk", (th % 2) == 1, vga_clk);
            end
            current_test = pixel_test;
            actual = {vga_r, vga_g, vga_b};
            check_rgb("vga_rgb", pixel_color(ph[1], pv[1]), actual);
            step();
        end
    endtask

    task automatic report_test(input int n, input string what);
        if (test_errors[n] == 0) begin
            $display("Test %0d %s: ok", n, what);
        end else begin
            $display("Test %0d %s: %0d errors", n, what, test_errors[n]);
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(24));
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        th = 0;
        tv = 0;
        ph = '{0, 0};
        pv = '{0, 0};
        test_errors = '{0, 0, 0, 0, 0};
        reset_regs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        current_test = 1;
        check_bit("wb_ack", 1'b0, wb_ack);
        check_rgb("vga_rgb", '0, {vga_r, vga_g, vga_b});
        check_bit("vga_hs", 1'b1, vga_hs);
        check_bit("vga_vs", 1'b1, vga_vs);
        check_bit("vga_sync_n", 1'b0, vga_sync_n);
        for (int a = 0; a < 4; a++) begin
            bus_access(1'b0, wb_addr_t'(a), '0, rdata);
            check_word("wb_dat_r", read_reg(wb_addr_t'(a)), rdata);
        end
        report_test(1, "reset state");

        current_test = 2;
        for (int i = 0; i < 16; i++) begin
            adr  = $urandom_range(0, 3);
            data = $urandom;
            bus_access(1'b1, adr, data, rdata);
            write_reg(adr, data);
            bus_access(1'b0, adr, '0, rdata);
            check_word("wb_dat_r", read_reg(adr), rdata);
        end
        report_test(2, "register readback");

        // Back to the reset scene before the frame checks
        reset_regs();
        for (int a = 0; a < 4; a++) begin
            bus_access(1'b1, wb_addr_t'(a), read_reg(wb_addr_t'(a)), rdata);
        end
        step();
        step();
        check_frame(4, 1'b1);
        report_test(3, "sync timing");
        report_test(4, "reset scene frame");

        current_test = 5;
        while (!(tv == `V_ACTIVE && th == 0)) begin
            step();
        end
        data = $urandom & 32'h00FF_FFFF;
        bus_access(1'b1, `REG_SKY, data, rdata);
        write_reg(`REG_SKY, data);
        data = $urandom_range(0, `H_ACTIVE - 3 * `DIGIT_PITCH);
        bus_access(1'b1, `REG_SCORE_X, data, rdata);
        write_reg(`REG_SCORE_X, data);
        data = $urandom_range(0, `V_ACTIVE - `GLYPH_SIZE);
        bus_access(1'b1, `REG_SCORE_Y, data, rdata);
        write_reg(`REG_SCORE_Y, data);
        for (int k = 0; k < 3; k++) begin
            new_score[k] = $urandom_range(0, 15);
        end
        // At least one slot gets a code that draws nothing
        new_score[$urandom_range(0, 2)] = $urandom_range(10, 15);
        bus_access(1'b1, `REG_SCORE, wb_data_t'(new_score), rdata);
        write_reg(`REG_SCORE, wb_data_t'(new_score));
        $display("Scene: sky %h at x %0d y %0d, digits %h", reg_sky, reg_score_x,
                 reg_score_y, reg_score);
        while (!(th == 0 && tv == 0)) begin
            step();
        end
        step();
        step();
        check_frame(5, 1'b0);
        report_test(5, "random scene frame");

        $display("Tests: 5 run, %0d failed, %0d check errors, %0d cycles",
                 tests_failed, errors, cycles);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/scene_cfg_if.sv
verilog/vga_counters.sv
verilog/scene_regs.sv
verilog/glyph_rom.sv
verilog/scene_renderer.sv
verilog/vga_scene.sv
verification/scene_model_pkg.sv
verification/tb_vga_scene.sv

// File: Bender.yml
package:
  name: vga_scene

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/video_pkg.sv
      - verilog/bus_pkg.sv
      - verilog/scene_cfg_if.sv
      - verilog/vga_counters.sv
      - verilog/scene_regs.sv
      - verilog/glyph_rom.sv
      - verilog/scene_renderer.sv
      - verilog/vga_scene.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/scene_model_pkg.sv
      - verification/tb_vga_scene.sv
